//--- files.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/instr_decoder.sv
verilog/hazard_unit.sv
verilog/fetch_stage.sv
verilog/cpu_core.sv
tests/cpu_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpu_core_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/cpu_stim.txt
# t <name>           starts a test
# p <addr> <word>    program word loaded at a byte address, hex
# e <reg> <value>    expected write-back in order, hex
t alu
p 00000000 20010005
p 00000004 2002fffd
p 00000008 340300f0
p 0000000c 30440ff0
p 00000010 3c051234
p 00000014 00223020
p 00000018 00233823
p 0000001c 00644024
p 00000020 00254825
p 00000024 0041502a
p 00000028 0022582a
p 0000002c 0800000b
e 01 00000005
e 02 fffffffd
e 03 000000f0
e 04 00000ff0
e 05 12340000
e 06 00000002
e 07 ffffff15
e 08 000000f0
e 09 12340005
e 0a 00000001
e 0b 00000000

t forwarding
p 00000000 20010007
p 00000004 00211020
p 00000008 00411823
p 0000000c 00622025
p 00000010 08000004
e 01 00000007
e 02 0000000e
e 03 00000007
e 04 0000000f

t load_use
p 00000000 20010040
p 00000004 20021234
p 00000008 ac220004
p 0000000c 8c230004
p 00000010 00622020
p 00000014 08000005
e 01 00000040
e 02 00001234
e 03 00001234
e 04 00002468

t branch_jump
p 00000000 20010003
p 00000004 20020003
p 00000008 10220001
p 0000000c 20030099
p 00000010 10200001
p 00000014 20040044
p 00000018 08000008
p 0000001c 20050055
p 00000020 20060066
p 00000024 08000009
e 01 00000003
e 02 00000003
e 04 00000044
e 06 00000066

t reg_zero
p 00000000 20000077
p 00000004 20010001
p 00000008 00001020
p 0000000c 00011825
p 00000010 08000004
e 01 00000001
e 02 00000000
e 03 00000001

//--- tests/cpu_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core_tb;

	localparam string stim_path = "tests/cpu_stim.txt";
	localparam int    drain_cycles = 8;

	logic               clock;
	logic               reset;
	logic               load_en;
	isa_pkg::word_t     load_addr;
	isa_pkg::word_t     load_data;
	logic               wb_valid;
	isa_pkg::reg_addr_t wb_reg;
	isa_pkg::word_t     wb_data;

	string              test_names[$];
	int                 prog_first[$];
	int                 prog_count[$];
	int                 exp_first[$];
	int                 exp_count[$];
	isa_pkg::word_t     prog_addr[$];
	isa_pkg::word_t     prog_word[$];
	isa_pkg::reg_addr_t exp_reg[$];
	isa_pkg::word_t     exp_val[$];
	int                 errors;      // mismatches in the running test
	int                 passed;
	int                 failed;
	int                 cycles;
	int                 cycle_limit;

	cpu_core uut (
		.clock(clock), .reset(reset), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#50 clock = ~clock;
	end

	task automatic check_reg(input isa_pkg::reg_addr_t got, input isa_pkg::reg_addr_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] wb_reg: got 0x%h, expected 0x%h", got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input isa_pkg::word_t got, input isa_pkg::word_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] wb_data: got 0x%h, expected 0x%h", got, exp);
			errors++;
		end
	endtask

	// returns 0 when the file is missing or holds no test
	function automatic int read_stim();
		int                 fd;
		int                 cur;
		string              line;
		string              name;
		isa_pkg::word_t     a;
		isa_pkg::word_t     w;
		isa_pkg::reg_addr_t r;
		fd = $fopen(stim_path, "r");
		if (fd == 0)
			return 0;
		cur = -1;
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2)
				continue;
			case (line.getc(0))
				"t":
				begin
					void'($sscanf(line, "t %s", name));
					test_names.push_back(name);
					prog_first.push_back(prog_addr.size());
					prog_count.push_back(0);
					exp_first.push_back(exp_reg.size());
					exp_count.push_back(0);
					cur = test_names.size() - 1;
				end
				"p":
					if (cur >= 0 && $sscanf(line, "p %h %h", a, w) == 2)
					begin
						prog_addr.push_back(a);
						prog_word.push_back(w);
						prog_count[cur] = prog_count[cur] + 1;
					end
				"e":
					if (cur >= 0 && $sscanf(line, "e %h %h", r, w) == 2)
					begin
						exp_reg.push_back(r);
						exp_val.push_back(w);
						exp_count[cur] = exp_count[cur] + 1;
					end
				default: ; // comment or blank line
			endcase
		end
		$fclose(fd);
		cycle_limit = 20 * test_names.size() + 6 * prog_addr.size();
		return (test_names.size() > 0) ? 1 : 0;
	endfunction

	task automatic run_test(input int t);
		int i;
		int got;
		errors = 0;
		got = 0;
		@(negedge clock);
		reset = 1'b0;
		for (i = 0; i < prog_count[t]; i++)
		begin
			load_en   = 1'b1;
			load_addr = prog_addr[prog_first[t] + i];
			load_data = prog_word[prog_first[t] + i];
			@(negedge clock);
		end
		load_en = 1'b0;
		repeat (5)
			@(negedge clock); // reset held after the load
		reset = 1'b1;
		while (got < exp_count[t])
		begin
			@(negedge clock);
			if (wb_valid === 1'b1)
			begin
				check_reg(wb_reg, exp_reg[exp_first[t] + got]);
				check_word(wb_data, exp_val[exp_first[t] + got]);
				got++;
			end
		end
		repeat (drain_cycles)
		begin
			@(negedge clock);
			if (wb_valid !== 1'b0)
			begin
				$display("unexpected write-back to register %0d after the last expected one",
					wb_reg);
				errors++;
			end
		end
		if (errors == 0)
		begin
			passed++;
			$display("test %s: ok", test_names[t]);
		end
		else
		begin
			failed++;
			$display("test %s: %0d errors", test_names[t], errors);
		end
	endtask

	initial
	begin
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("timed out waiting for write-back");
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		reset       = 1'b0;
		load_en     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		errors      = 0;
		passed      = 0;
		failed      = 0;
		cycle_limit = 0;
		if (read_stim() == 0)
		begin
			$display("could not read any test from %s", stim_path);
			$display("Testbench failed");
			$finish;
		end
		else
		begin
			foreach (test_names[t])
				run_test(t);
			$display("tests run: %0d, ok: %0d, failing: %0d", passed + failed, passed, failed);
			if (failed == 0)
				$display("Testbench passed");
			else
				$display("Testbench failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verilog/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core #(
	parameter int             imem_words = 1024,
	parameter int             dmem_words = 1024,
	parameter isa_pkg::word_t reset_pc   = '0
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               load_en,
	input  isa_pkg::word_t     load_addr,
	input  isa_pkg::word_t     load_data,
	output logic               wb_valid,
	output isa_pkg::reg_addr_t wb_reg,
	output isa_pkg::word_t     wb_data
);

	localparam int dw = $clog2(dmem_words);

	isa_pkg::word_t     if_pc, if_instr, if_id_pc, if_id_instr;
	isa_pkg::reg_addr_t id_rs, id_rt;
	pipe_pkg::ctrl_t    id_ctrl;
	isa_pkg::word_t     id_imm, branch_target, jump_target;
	isa_pkg::word_t     rs_data, rt_data, id_a, id_b;
	logic               stall, flush, branch_taken;
	pipe_pkg::fwd_sel_t fwd_a, fwd_b, dec_fwd_a, dec_fwd_b;
	pipe_pkg::id_ex_t   id_ex;
	pipe_pkg::ex_mem_t  ex_mem;
	pipe_pkg::mem_wb_t  mem_wb;
	isa_pkg::word_t     ex_a, ex_b, alu_b, alu_result;
	isa_pkg::word_t     dmem [dmem_words];
	isa_pkg::word_t     mem_result;

	function automatic isa_pkg::word_t fwd_value(pipe_pkg::fwd_sel_t sel,
		isa_pkg::word_t reg_val, isa_pkg::word_t mem_val, isa_pkg::word_t wb_val);
		case (sel)
			pipe_pkg::from_mem: return mem_val;
			pipe_pkg::from_wb:  return wb_val;
			default:            return reg_val;
		endcase
	endfunction

	fetch_stage #(.imem_words(imem_words), .reset_pc(reset_pc)) u_fetch (
		.clock(clock), .reset(reset), .stall(stall),
		.branch_taken(branch_taken), .jump(id_ctrl.is_jump),
		.branch_target(branch_target), .jump_target(jump_target),
		.load_en(load_en), .load_addr(load_addr), .load_data(load_data),
		.pc(if_pc), .instr(if_instr)
	);

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			if_id_pc    <= '0;
			if_id_instr <= '0;
		end
		else if (flush)
			if_id_instr <= '0; // sll r0 acts as nop
		else if (!stall)
		begin
			if_id_pc    <= if_pc;
			if_id_instr <= if_instr;
		end
	end

	assign id_rs = if_id_instr[25:21];
	assign id_rt = if_id_instr[20:16];

	instr_decoder u_decoder (
		.instr(if_id_instr), .pc(if_id_pc), .ctrl(id_ctrl), .imm_ext(id_imm),
		.branch_target(branch_target), .jump_target(jump_target)
	);

	reg_file u_regs (
		.clock(clock), .rs(id_rs), .rt(id_rt),
		.rs_data(rs_data), .rt_data(rt_data), .wb(mem_wb)
	);

	hazard_unit u_hazard (
		.id_rs(id_rs), .id_rt(id_rt), .id_ctrl(id_ctrl), .id_ex(id_ex),
		.ex_mem(ex_mem), .mem_wb(mem_wb), .branch_taken(branch_taken),
		.stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.dec_fwd_a(dec_fwd_a), .dec_fwd_b(dec_fwd_b)
	);

	assign id_a = fwd_value(dec_fwd_a, rs_data, mem_result, mem_wb.result);
	assign id_b = fwd_value(dec_fwd_b, rt_data, mem_result, mem_wb.result);
	assign branch_taken = id_ctrl.is_branch && (id_a == id_b); // beq resolved in decode

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			id_ex <= '0;
		else if (stall)
			id_ex.ctrl <= '0; // bubble
		else
			id_ex <= '{ctrl: id_ctrl, rs: id_rs, rt: id_rt, a: id_a, b: id_b, imm: id_imm};
	end

	assign ex_a  = fwd_value(fwd_a, id_ex.a, ex_mem.result, mem_wb.result);
	assign ex_b  = fwd_value(fwd_b, id_ex.b, ex_mem.result, mem_wb.result);
	assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : ex_b;

	alu u_alu (.a(ex_a), .b(alu_b), .op(id_ex.ctrl.alu_op), .result(alu_result));

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			ex_mem <= '0;
		else
			ex_mem <= '{ctrl: id_ex.ctrl, result: alu_result, store_data: ex_b};
	end

	always_ff @(posedge clock)
	begin
		if (ex_mem.ctrl.mem_write)
			dmem[ex_mem.result[dw+1:2]] <= ex_mem.store_data;
	end

	assign mem_result = ex_mem.ctrl.mem_to_reg ? dmem[ex_mem.result[dw+1:2]] : ex_mem.result;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			mem_wb <= '0;
		else
			mem_wb <= '{reg_write: ex_mem.ctrl.reg_write && ex_mem.ctrl.dest != '0,
				dest: ex_mem.ctrl.dest, result: mem_result};
	end

	assign wb_valid = mem_wb.reg_write;
	assign wb_reg   = mem_wb.dest;
	assign wb_data  = mem_wb.result;

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
	parameter int             imem_words = 1024,
	parameter isa_pkg::word_t reset_pc   = '0
) (
	input  logic           clock,
	input  logic           reset,
	input  logic           stall,
	input  logic           branch_taken,
	input  logic           jump,
	input  isa_pkg::word_t branch_target,
	input  isa_pkg::word_t jump_target,
	input  logic           load_en,
	input  isa_pkg::word_t load_addr,
	input  isa_pkg::word_t load_data,
	output isa_pkg::word_t pc,
	output isa_pkg::word_t instr
);

	localparam int aw = $clog2(imem_words);

	isa_pkg::word_t imem [imem_words];
	isa_pkg::word_t next_pc;

	always_ff @(posedge clock)
	begin
		if (load_en)
			imem[load_addr[aw+1:2]] <= load_data; // byte address to word index
	end

	assign instr = imem[pc[aw+1:2]];

	always_comb
	begin
		if (jump)
			next_pc = jump_target;
		else if (branch_taken)
			next_pc = branch_target;
		else
			next_pc = pc + 32'd4;
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			pc <= reset_pc;
		else if (!stall) // redirect waits for the stall to clear
			pc <= next_pc;
	end

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
	input  isa_pkg::reg_addr_t id_rs,
	input  isa_pkg::reg_addr_t id_rt,
	input  pipe_pkg::ctrl_t    id_ctrl,
	input  pipe_pkg::id_ex_t   id_ex,
	input  pipe_pkg::ex_mem_t  ex_mem,
	input  pipe_pkg::mem_wb_t  mem_wb,
	input  logic               branch_taken,
	output logic               stall,
	output logic               flush,
	output pipe_pkg::fwd_sel_t fwd_a,
	output pipe_pkg::fwd_sel_t fwd_b,
	output pipe_pkg::fwd_sel_t dec_fwd_a,
	output pipe_pkg::fwd_sel_t dec_fwd_b
);

	logic ex_writes;
	logic mem_writes;
	logic mem_alu_writes;
	logic wb_writes;
	logic ex_hit;

	function automatic pipe_pkg::fwd_sel_t select_src(logic mem_hit, logic wb_hit);
		if (mem_hit)
			return pipe_pkg::from_mem; // newest value wins
		else if (wb_hit)
			return pipe_pkg::from_wb;
		else
			return pipe_pkg::from_reg;
	endfunction

	assign ex_writes      = id_ex.ctrl.reg_write && id_ex.ctrl.dest != '0;
	assign mem_writes     = ex_mem.ctrl.reg_write && ex_mem.ctrl.dest != '0;
	assign mem_alu_writes = mem_writes && !ex_mem.ctrl.mem_to_reg;
	assign wb_writes      = mem_wb.reg_write && mem_wb.dest != '0;

	assign fwd_a = select_src(mem_alu_writes && ex_mem.ctrl.dest == id_ex.rs,
		wb_writes && mem_wb.dest == id_ex.rs);
	assign fwd_b = select_src(mem_alu_writes && ex_mem.ctrl.dest == id_ex.rt,
		wb_writes && mem_wb.dest == id_ex.rt);

	// decode taps the full memory-stage result, so loads are fine here
	assign dec_fwd_a = select_src(mem_writes && ex_mem.ctrl.dest == id_rs,
		wb_writes && mem_wb.dest == id_rs);
	assign dec_fwd_b = select_src(mem_writes && ex_mem.ctrl.dest == id_rt,
		wb_writes && mem_wb.dest == id_rt);

	assign ex_hit = ex_writes && (id_ex.ctrl.dest == id_rs || id_ex.ctrl.dest == id_rt);
	assign stall  = ex_hit && (id_ex.ctrl.mem_to_reg || id_ctrl.is_branch); // load-use or beq wait
	assign flush  = (branch_taken || id_ctrl.is_jump) && !stall;

endmodule

`default_nettype wire

//--- verilog/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
	input  isa_pkg::word_t  instr,
	input  isa_pkg::word_t  pc,
	output pipe_pkg::ctrl_t ctrl,
	output isa_pkg::word_t  imm_ext,
	output isa_pkg::word_t  branch_target,
	output isa_pkg::word_t  jump_target
);

	isa_pkg::opcode_t   opcode;
	isa_pkg::funct_t    funct;
	isa_pkg::imm_t      imm;
	isa_pkg::reg_addr_t rt;
	isa_pkg::reg_addr_t rd;
	isa_pkg::word_t     pc_plus4;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign imm    = instr[15:0];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	always_comb
	begin
		ctrl = '0; // undefined opcodes stay a no-op
		case (opcode)
			isa_pkg::op_rtype:
			begin
				case (funct)
					isa_pkg::funct_add,
					isa_pkg::funct_addu: ctrl.alu_op = isa_pkg::add; // no overflow trap
					isa_pkg::funct_subu: ctrl.alu_op = isa_pkg::sub;
					isa_pkg::funct_and:  ctrl.alu_op = isa_pkg::and_op;
					isa_pkg::funct_or:   ctrl.alu_op = isa_pkg::or_op;
					isa_pkg::funct_slt:  ctrl.alu_op = isa_pkg::slt;
					default:             ctrl.alu_op = isa_pkg::pass_a;
				endcase
				ctrl.reg_write = (ctrl.alu_op != isa_pkg::pass_a); // unknown funct writes nothing
				ctrl.dest      = rd;
			end
			isa_pkg::op_addi,
			isa_pkg::op_addiu:
			begin
				ctrl.alu_op    = isa_pkg::add;
				ctrl.use_imm   = 1'b1;
				ctrl.sign_ext  = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest      = rt;
			end
			isa_pkg::op_andi:
			begin
				ctrl.alu_op    = isa_pkg::and_op;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest      = rt;
			end
			isa_pkg::op_ori:
			begin
				ctrl.alu_op    = isa_pkg::or_op;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest      = rt;
			end
			isa_pkg::op_lui:
			begin
				ctrl.alu_op    = isa_pkg::lui;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest      = rt;
			end
			isa_pkg::op_lw:
			begin
				ctrl.alu_op     = isa_pkg::add; // address calc
				ctrl.use_imm    = 1'b1;
				ctrl.sign_ext   = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.dest       = rt;
			end
			isa_pkg::op_sw:
			begin
				ctrl.alu_op    = isa_pkg::add;
				ctrl.use_imm   = 1'b1;
				ctrl.sign_ext  = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			isa_pkg::op_beq:
			begin
				ctrl.sign_ext  = 1'b1;
				ctrl.is_branch = 1'b1;
			end
			isa_pkg::op_j:   ctrl.is_jump = 1'b1;
			default:         ctrl = '0;
		endcase
	end

	assign imm_ext = ctrl.sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};

	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
	assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00}; // same 256MB region

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  logic               clock,
	input  isa_pkg::reg_addr_t rs,
	input  isa_pkg::reg_addr_t rt,
	output isa_pkg::word_t     rs_data,
	output isa_pkg::word_t     rt_data,
	input  pipe_pkg::mem_wb_t  wb
);

	isa_pkg::word_t regs [32];

	always_ff @(posedge clock)
	begin
		if (wb.reg_write && wb.dest != '0)
			regs[wb.dest] <= wb.result;
	end

	// r0 is hardwired
	assign rs_data = (rs == '0) ? '0 : regs[rs];
	assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  isa_pkg::word_t   a,
	input  isa_pkg::word_t   b,
	input  isa_pkg::alu_op_t op,
	output isa_pkg::word_t   result
);

	always_comb
	begin
		case (op)
			isa_pkg::pass_a: result = a;
			isa_pkg::add:    result = a + b; // wraps, add and addu alike
			isa_pkg::sub:    result = a - b;
			isa_pkg::and_op: result = a & b;
			isa_pkg::or_op:  result = a | b;
			isa_pkg::slt:    result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			isa_pkg::lui:    result = {b[15:0], 16'h0000};
			default:         result = a;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	typedef enum logic [1:0] {
		from_reg,
		from_mem,
		from_wb
	} fwd_sel_t;

	typedef struct packed {
		isa_pkg::alu_op_t  alu_op;
		logic              use_imm;    // operand b is the immediate
		logic              sign_ext;
		logic              reg_write;
		logic              mem_write;
		logic              mem_to_reg;
		isa_pkg::reg_addr_t dest;
		logic              is_branch;
		logic              is_jump;
	} ctrl_t;

	typedef struct packed {
		ctrl_t              ctrl;
		isa_pkg::reg_addr_t rs;
		isa_pkg::reg_addr_t rt;
		isa_pkg::word_t     a;
		isa_pkg::word_t     b;
		isa_pkg::word_t     imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t          ctrl;
		isa_pkg::word_t result;
		isa_pkg::word_t store_data;
	} ex_mem_t;

	typedef struct packed {
		logic               reg_write;
		isa_pkg::reg_addr_t dest;
		isa_pkg::word_t     result;
	} mem_wb_t;

endpackage

`default_nettype wire

//--- verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [31:0] word_t;     // data, address or instruction
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [15:0] imm_t;

	// primary opcodes
	localparam opcode_t op_rtype = 6'b000000;
	localparam opcode_t op_addi  = 6'b001000;
	localparam opcode_t op_addiu = 6'b001001;
	localparam opcode_t op_andi  = 6'b001100;
	localparam opcode_t op_ori   = 6'b001101;
	localparam opcode_t op_lui   = 6'b001111;
	localparam opcode_t op_lw    = 6'b100011;
	localparam opcode_t op_sw    = 6'b101011;
	localparam opcode_t op_beq   = 6'b000100;
	localparam opcode_t op_j     = 6'b000010;

	// R-type function codes
	localparam funct_t funct_add  = 6'b100000;
	localparam funct_t funct_addu = 6'b100001;
	localparam funct_t funct_subu = 6'b100011;
	localparam funct_t funct_and  = 6'b100100;
	localparam funct_t funct_or   = 6'b100101;
	localparam funct_t funct_slt  = 6'b101010;

	typedef enum logic [2:0] {
		pass_a,
		add,
		sub,
		and_op,
		or_op,
		slt,
		lui
	} alu_op_t;

endpackage

`default_nettype wire
